/* eth_tx_path.f */
design/mac_tx_pkg.sv
design/tx_buf_pkg.sv
design/frame_buffer.sv
design/frame_ingest.sv
design/frame_scheduler.sv
design/tx_frame_sender.sv
design/eth_tx_path.sv
tests/tb_eth_tx_path.sv

/* run_sim.sh */
#!/bin/sh
# build the tx path testbench with verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1

OBJ=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -j 0 -f eth_tx_path.f --top-module tb_eth_tx_path \
    --Mdir "$OBJ" -o sim_tb > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed with status $status"
    exit 1
fi

"./$OBJ/sim_tb" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '>>> FAIL' "$SIM_LOG"; then
    exit 1
fi
exit 0

/* tests/tb_eth_tx_path.sv */
// tx path testbench
`timescale 1ns/1ps
`default_nettype none

module tb_eth_tx_path;

    localparam int NTEST = 8;

    typedef struct {
        string             name;
        int                len;         // qwords of the first frame
        int                cnt;         // frames in a row, each one qword longer
        mac_tx_pkg::ben_t  lben;
        logic [31:0]       dseed;
        int                stall_at;    // host pauses after this qword, -1 none
        int                stall_len;
        int                ack_dly;     // mac ack delay in cycles
        bit                exp_full;
    } test_t;

    logic                clk;
    logic                rst;
    logic                wr_sof, wr_en, tx_ack;
    mac_tx_pkg::qw_len_t wr_len;
    mac_tx_pkg::ben_t    wr_lben;
    mac_tx_pkg::qword_t  wr_data;
    logic                buf_full, tx_start, tx_underrun;
    mac_tx_pkg::qword_t  tx_data;
    mac_tx_pkg::ben_t    tx_valid;

    test_t               tbl [NTEST];
    mac_tx_pkg::qword_t  exp_q[$], rx_data_q[$], cur_data_q[$];
    mac_tx_pkg::ben_t    rx_ben_q[$], cur_ben_q[$];
    mac_tx_pkg::qw_len_t exp_len_q[$], rx_len_q[$];
    mac_tx_pkg::qword_t  held_qw;
    integer              seed;
    int                  errors = 0, checks = 0, frames_rx = 0, starts = 0, underruns = 0;
    int                  cur_ack = 0, ack_wait = 0, limit_cycles = 0;
    bit                  ack_armed = 0, in_frame = 0, got_ack = 0, hold_first = 0;
    bit                  full_seen = 0;

    eth_tx_path dut_i (
        .clk(clk), .rst(rst),
        .wr_sof_i(wr_sof), .wr_len_i(wr_len), .wr_lben_i(wr_lben),
        .wr_en_i(wr_en), .wr_data_i(wr_data), .buf_full_o(buf_full),
        .tx_start_o(tx_start), .tx_ack_i(tx_ack), .tx_data_o(tx_data),
        .tx_data_valid_o(tx_valid), .tx_underrun_o(tx_underrun)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;          // 100 MHz
    end

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////
    task automatic check_qword(input mac_tx_pkg::qword_t got, input mac_tx_pkg::qword_t exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_ben(input mac_tx_pkg::ben_t got, input mac_tx_pkg::ben_t exp,
                             input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_len(input mac_tx_pkg::qw_len_t got, input mac_tx_pkg::qw_len_t exp,
                             input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // frame table and host driver
    //////////////////////////////////////////////////////////////////////
    task automatic load_table();
        tbl[0] = '{name: "single min frame", len: 3, cnt: 1, lben: 8'h01, dseed: 32'h11,
                   stall_at: -1, stall_len: 0, ack_dly: 0, exp_full: 1'b0};
        tbl[1] = '{name: "ack delay 1", len: 10, cnt: 1, lben: 8'h3f, dseed: 32'h22,
                   stall_at: -1, stall_len: 0, ack_dly: 1, exp_full: 1'b0};
        tbl[2] = '{name: "ack delay 3", len: 7, cnt: 1, lben: 8'h7f, dseed: 32'h33,
                   stall_at: -1, stall_len: 0, ack_dly: 3, exp_full: 1'b0};
        tbl[3] = '{name: "ack delay 6", len: 16, cnt: 1, lben: 8'hff, dseed: 32'h44,
                   stall_at: -1, stall_len: 0, ack_dly: 6, exp_full: 1'b0};
        tbl[4] = '{name: "three frames queued", len: 5, cnt: 3, lben: 8'h0f, dseed: 32'h55,
                   stall_at: -1, stall_len: 0, ack_dly: 2, exp_full: 1'b0};
        tbl[5] = '{name: "host stall underrun", len: 40, cnt: 1, lben: 8'h03, dseed: 32'h66,
                   stall_at: 8, stall_len: 60, ack_dly: 4, exp_full: 1'b0};
        tbl[6] = '{name: "buffer full", len: 511, cnt: 2, lben: 8'h07, dseed: 32'h77,
                   stall_at: -1, stall_len: 0, ack_dly: 5, exp_full: 1'b1};
        tbl[7] = '{name: "two frames ack 0", len: 24, cnt: 2, lben: 8'h1f, dseed: 32'h88,
                   stall_at: -1, stall_len: 0, ack_dly: 0, exp_full: 1'b0};
    endtask

    // all lengths, stalls and ack delays, x4, plus margin
    function automatic int calc_limit();
        int sum;
        sum = 0;
        for (int t = 0; t < NTEST; t++) begin
            for (int k = 0; k < tbl[t].cnt; k++) begin
                sum += tbl[t].len + k + tbl[t].stall_len + tbl[t].ack_dly;
            end
        end
        return sum * 4 + 200;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;                             // drive just after the edge
    endtask

    task automatic write_frame(input int t, input int k);
        int                 len;
        mac_tx_pkg::qword_t q;
        len = tbl[t].len + k;
        exp_len_q.push_back(mac_tx_pkg::qw_len_t'(len));
        for (int i = 0; i < len; i++) begin
            next_cycle();
            wr_sof = 1'b0;
            wr_en  = 1'b0;
            if (tbl[t].stall_at >= 0 && i == tbl[t].stall_at + 1) begin
                repeat (tbl[t].stall_len) next_cycle();   // host falls behind
            end
            while (buf_full) begin
                next_cycle();                              // no writes while full
            end
            q = {$random(seed) ^ tbl[t].dseed, $random(seed)};
            wr_sof  = (i == 0);         // announce with the first qword
            wr_len  = mac_tx_pkg::qw_len_t'(len);
            wr_lben = tbl[t].lben;
            wr_en   = 1'b1;
            wr_data = q;
            exp_q.push_back(q);
        end
        next_cycle();
        wr_sof = 1'b0;
        wr_en  = 1'b0;
    endtask

    // expected bens: all ones, table value on the last qword
    task automatic check_frame(input int t, input int k);
        mac_tx_pkg::qw_len_t elen, rlen;
        mac_tx_pkg::qword_t  eq, dq;
        mac_tx_pkg::ben_t    eben, db;
        elen = exp_len_q.pop_front();
        rlen = rx_len_q.pop_front();
        check_len(rlen, elen, $sformatf("test %0d frame %0d length", t, k));
        for (int i = 0; i < int'(rlen); i++) begin
            dq = rx_data_q.pop_front();
            db = rx_ben_q.pop_front();
            if (i < int'(elen)) begin
                eq   = exp_q.pop_front();
                eben = (i == int'(elen) - 1) ? tbl[t].lben : 8'hff;
                check_qword(dq, eq, $sformatf("test %0d frame %0d qword %0d", t, k, i));
                check_ben(db, eben, $sformatf("test %0d frame %0d ben %0d", t, k, i));
            end
        end
        for (int i = int'(rlen); i < int'(elen); i++) begin
            eq = exp_q.pop_front();     // short frame, drop the rest
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // mac model
    //////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        #1;
        if (ack_armed && ack_wait == 0) begin
            tx_ack    = 1'b1;           // single cycle ack
            ack_armed = 1'b0;
        end else begin
            tx_ack = 1'b0;
            if (ack_armed) ack_wait--;
        end
    end

    always @(negedge clk) begin         // sample mid cycle
        if (!rst) begin
            if (buf_full) full_seen = 1'b1;
            if (tx_underrun) begin
                underruns++;
                cur_data_q.delete();    // frame will be sent again
                cur_ben_q.delete();
                in_frame = 1'b0;
            end else if (in_frame && got_ack && tx_valid == '0) begin
                foreach (cur_data_q[i]) rx_data_q.push_back(cur_data_q[i]);
                foreach (cur_ben_q[i]) rx_ben_q.push_back(cur_ben_q[i]);
                rx_len_q.push_back(mac_tx_pkg::qw_len_t'(cur_data_q.size()));
                cur_data_q.delete();
                cur_ben_q.delete();
                frames_rx++;
                in_frame = 1'b0;
            end
            if (tx_start) begin
                starts++;
                if (in_frame) begin
                    errors++;
                    $display("error at %0t: tx_start while a frame is still open", $time);
                end
                in_frame   = 1'b1;
                got_ack    = 1'b0;
                hold_first = 1'b1;
                ack_wait   = cur_ack;
                ack_armed  = 1'b1;
            end
            if (tx_valid != '0) begin
                if (!in_frame) begin
                    errors++;
                    $display("error at %0t: data valid seen outside a frame", $time);
                end else if (!got_ack) begin
                    if (hold_first) begin
                        held_qw    = tx_data;
                        hold_first = 1'b0;
                    end else begin
                        check_qword(tx_data, held_qw, "first qword held for ack");
                    end
                    if (tx_ack) begin   // accepted here
                        cur_data_q.push_back(tx_data);
                        cur_ben_q.push_back(tx_valid);
                        got_ack = 1'b1;
                    end
                end else begin
                    cur_data_q.push_back(tx_data);
                    cur_ben_q.push_back(tx_valid);
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // watchdog and main sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", limit_cycles);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        int err0, s0, u0, fr0, failed;
        rst     = 1'b1;
        wr_sof  = 1'b0;
        wr_len  = '0;
        wr_lben = '0;
        wr_en   = 1'b0;
        wr_data = '0;
        tx_ack  = 1'b0;
        seed    = 65494;
        failed  = 0;
        load_table();
        limit_cycles = calc_limit();

        repeat (8) next_cycle();
        rst  = 1'b0;
        err0 = errors;
        for (int c = 0; c < 6; c++) begin   // idle outputs before any write
            next_cycle();
            check_level(tx_start, 1'b0, "tx_start after reset");
            check_level(tx_underrun, 1'b0, "tx_underrun after reset");
            check_level(buf_full, 1'b0, "buf_full after reset");
            check_ben(tx_valid, 8'h00, "tx_data_valid after reset");
        end
        if (errors != err0) failed++;
        $display("test reset outputs: %s", (errors == err0) ? "ok" : "FAILED");

        for (int t = 0; t < NTEST; t++) begin
            err0      = errors;
            s0        = starts;
            u0        = underruns;
            fr0       = frames_rx;
            full_seen = 1'b0;
            cur_ack   = tbl[t].ack_dly;
            for (int k = 0; k < tbl[t].cnt; k++) begin
                write_frame(t, k);
            end
            while (frames_rx < fr0 + tbl[t].cnt) begin
                next_cycle();
            end
            repeat (4) next_cycle();
            for (int k = 0; k < tbl[t].cnt; k++) begin
                check_frame(t, k);
            end
            if (tbl[t].stall_at < 0) begin
                check_count(starts - s0, tbl[t].cnt, "tx_start pulses");
            end else begin
                check_level(underruns != u0, 1'b1, "tx_underrun seen");
            end
            if (tbl[t].exp_full) begin
                check_level(full_seen, 1'b1, "buf_full seen");
            end
            if (errors != err0) failed++;
            $display("test %0d %s: %s", t, tbl[t].name, (errors == err0) ? "ok" : "FAILED");
        end

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 NTEST + 1, failed, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/eth_tx_path.sv */
// 10g ethernet transmit path
`timescale 1ns/1ps
`default_nettype none

module eth_tx_path #(
    parameter int BW       = tx_buf_pkg::DEFAULT_BW,
    parameter int DESC_AW  = tx_buf_pkg::DEFAULT_DESC_AW,
    parameter int START_QW = tx_buf_pkg::DEFAULT_START_QW
) (
    input  wire                        clk,
    input  wire                        rst,

    // host port
    input  wire                        wr_sof_i,
    input  wire mac_tx_pkg::qw_len_t   wr_len_i,
    input  wire mac_tx_pkg::ben_t      wr_lben_i,
    input  wire                        wr_en_i,
    input  wire mac_tx_pkg::qword_t    wr_data_i,
    output logic                       buf_full_o,

    // mac port
    output logic                       tx_start_o,
    input  wire                        tx_ack_i,
    output mac_tx_pkg::qword_t         tx_data_o,
    output mac_tx_pkg::ben_t           tx_data_valid_o,
    output logic                       tx_underrun_o
);

    logic                mem_we;
    logic [BW-1:0]       mem_waddr, rd_addr;
    mac_tx_pkg::qword_t  mem_wdata, rd_data;
    logic [BW:0]         prod, committed_cons, rd_ptr, diff;
    logic                desc_push, trig, rsk, rsk_tk, sync;
    mac_tx_pkg::qw_len_t desc_len, qw_len;
    mac_tx_pkg::ben_t    desc_lben, lst_ben;

    frame_buffer #(.BW(BW)) buf_i (
        .clk(clk), .wr_en_i(mem_we), .wr_addr_i(mem_waddr), .wr_data_i(mem_wdata),
        .rd_addr_i(rd_addr), .rd_data_o(rd_data)
    );

    frame_ingest #(.BW(BW), .DESC_AW(DESC_AW)) ingest_i (
        .clk(clk), .rst(rst), .wr_sof_i(wr_sof_i), .wr_len_i(wr_len_i),
        .wr_lben_i(wr_lben_i), .wr_en_i(wr_en_i), .wr_data_i(wr_data_i),
        .committed_cons_i(committed_cons), .buf_full_o(buf_full_o),
        .mem_we_o(mem_we), .mem_waddr_o(mem_waddr), .mem_wdata_o(mem_wdata),
        .prod_o(prod), .desc_push_o(desc_push), .desc_len_o(desc_len),
        .desc_lben_o(desc_lben)
    );

    frame_scheduler #(.BW(BW), .DESC_AW(DESC_AW), .START_QW(START_QW)) sched_i (
        .clk(clk), .rst(rst), .desc_push_i(desc_push), .desc_len_i(desc_len),
        .desc_lben_i(desc_lben), .prod_i(prod), .rd_ptr_i(rd_ptr), .sync_i(sync),
        .rsk_tk_i(rsk_tk), .tx_underrun_i(tx_underrun_o), .trig_o(trig),
        .qw_len_o(qw_len), .lst_ben_o(lst_ben), .rsk_o(rsk), .diff_o(diff)
    );

    tx_frame_sender #(.BW(BW)) sender_i (
        .clk(clk), .rst(rst), .tx_underrun_o(tx_underrun_o), .tx_data_o(tx_data_o),
        .tx_data_valid_o(tx_data_valid_o), .tx_start_o(tx_start_o), .tx_ack_i(tx_ack_i),
        .rd_addr_o(rd_addr), .rd_data_i(rd_data), .committed_cons_o(committed_cons),
        .rd_ptr_o(rd_ptr), .diff_i(diff), .trig_i(trig), .qw_len_i(qw_len),
        .lst_ben_i(lst_ben), .rsk_i(rsk), .rsk_tk_o(rsk_tk), .sync_o(sync)
    );

endmodule

`default_nettype wire

/* design/tx_frame_sender.sv */
// frame sender towards the 10g mac
`timescale 1ns/1ps
`default_nettype none

module tx_frame_sender #(
    parameter int BW = 9
) (
    input  wire                        clk,
    input  wire                        rst,

    // mac tx
    output logic                       tx_underrun_o,
    output mac_tx_pkg::qword_t         tx_data_o,
    output mac_tx_pkg::ben_t           tx_data_valid_o,
    output logic                       tx_start_o,
    input  wire                        tx_ack_i,

    // frame buffer
    output logic [BW-1:0]              rd_addr_o,
    input  wire mac_tx_pkg::qword_t    rd_data_i,

    // space check and scheduler
    output logic [BW:0]                committed_cons_o,
    output logic [BW:0]                rd_ptr_o,
    input  wire [BW:0]                 diff_i,
    input  wire                        trig_i,
    input  wire mac_tx_pkg::qw_len_t   qw_len_i,
    input  wire mac_tx_pkg::ben_t      lst_ben_i,
    input  wire                        rsk_i,
    output logic                       rsk_tk_o,
    output logic                       sync_o
);

    // one-hot states
    localparam logic [5:0] S_IDLE   = 6'b000001;
    localparam logic [5:0] S_START  = 6'b000010;
    localparam logic [5:0] S_FIRST  = 6'b000100;
    localparam logic [5:0] S_HOLD   = 6'b001000;
    localparam logic [5:0] S_STREAM = 6'b010000;
    localparam logic [5:0] S_UNDER  = 6'b100000;

    logic [5:0]          state;
    logic [BW:0]         sof_ptr;       // frame start, rewind target
    logic [BW:0]         cons_nxt;      // end of frame just sent
    logic                eof;
    logic                ack_pend;      // ack seen together with tx_start
    mac_tx_pkg::qw_len_t qw_snt;        // qwords already handed to the mac
    mac_tx_pkg::qword_t  first_qw;
    mac_tx_pkg::qword_t  spare_qw;      // parked while waiting for ack

    assign rd_addr_o = rd_ptr_o[BW-1:0];

    //////////////////////////////////////////////////////////////////////
    // send fsm
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state            <= S_IDLE;
            rd_ptr_o         <= '0;
            committed_cons_o <= '0;
            tx_start_o       <= 1'b0;
            tx_underrun_o    <= 1'b0;
            tx_data_valid_o  <= '0;
            sync_o           <= 1'b0;
            rsk_tk_o         <= 1'b0;
            eof              <= 1'b0;
            ack_pend         <= 1'b0;
        end else begin
            tx_start_o      <= 1'b0;
            tx_underrun_o   <= 1'b0;
            tx_data_valid_o <= '0;
            sync_o          <= 1'b0;
            rsk_tk_o        <= 1'b0;
            eof             <= 1'b0;
            if (eof) begin
                committed_cons_o <= cons_nxt;   // frame space freed
            end

            case (state)
                S_IDLE: begin                   // rd_ptr sits on next frame
                    if (trig_i) begin
                        sof_ptr  <= rd_ptr_o;
                        rd_ptr_o <= rd_ptr_o + 1'b1;
                        state    <= S_START;
                    end
                end
                S_START: begin
                    tx_start_o <= 1'b1;
                    rd_ptr_o   <= rd_ptr_o + 1'b1;
                    ack_pend   <= 1'b0;
                    state      <= S_FIRST;
                end
                S_FIRST: begin                  // qword 1 on the read port
                    tx_data_valid_o <= '1;
                    ack_pend        <= tx_ack_i;
                    state           <= S_HOLD;
                end
                S_HOLD: begin                   // first qword held for ack
                    tx_data_valid_o <= '1;
                    qw_snt <= mac_tx_pkg::qw_len_t'(mac_tx_pkg::MIN_FRAME_QW - 1);
                    if (tx_ack_i || ack_pend) begin
                        rd_ptr_o <= rd_ptr_o + 1'b1;
                        state    <= S_STREAM;
                    end
                end
                S_STREAM: begin                 // one qword per clock
                    rd_ptr_o        <= rd_ptr_o + 1'b1;
                    tx_data_valid_o <= '1;
                    qw_snt          <= qw_snt + 1'b1;
                    if (qw_snt == qw_len_i - 1'b1) begin
                        tx_data_valid_o <= lst_ben_i;
                        sync_o          <= 1'b1;
                        eof             <= 1'b1;
                        cons_nxt        <= rd_ptr_o;
                        if (rsk_i) begin        // chain next frame
                            rsk_tk_o <= 1'b1;
                            sof_ptr  <= rd_ptr_o;
                            state    <= S_START;
                        end else begin
                            rd_ptr_o <= rd_ptr_o;
                            state    <= S_IDLE;
                        end
                    end else if (diff_i == (BW+1)'(1) &&
                                 qw_snt != qw_len_i - 2'd2) begin
                        tx_underrun_o   <= 1'b1;   // host fell behind
                        tx_data_valid_o <= '0;
                        rd_ptr_o        <= sof_ptr;
                        state           <= S_UNDER;
                    end
                end
                S_UNDER: begin
                    sync_o <= 1'b1;             // attempt over, frame stays queued
                    state  <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // data path, prefetch and first qword hold
    always_ff @(posedge clk) begin
        case (state)
            S_START:  first_qw  <= rd_data_i;
            S_FIRST: begin
                tx_data_o <= first_qw;
                spare_qw  <= rd_data_i;
            end
            S_HOLD: begin
                if (tx_ack_i || ack_pend) begin
                    tx_data_o <= spare_qw;
                end
            end
            S_STREAM: tx_data_o <= rd_data_i;
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/frame_scheduler.sv */
// descriptor queue and frame release
`timescale 1ns/1ps
`default_nettype none

module frame_scheduler #(
    parameter int BW       = 9,
    parameter int DESC_AW  = 3,
    parameter int START_QW = 4
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        desc_push_i,
    input  wire mac_tx_pkg::qw_len_t   desc_len_i,
    input  wire mac_tx_pkg::ben_t      desc_lben_i,
    input  wire [BW:0]                 prod_i,
    input  wire [BW:0]                 rd_ptr_i,
    input  wire                        sync_i,
    input  wire                        rsk_tk_i,
    input  wire                        tx_underrun_i,
    output logic                       trig_o,
    output mac_tx_pkg::qw_len_t        qw_len_o,
    output mac_tx_pkg::ben_t           lst_ben_o,
    output logic                       rsk_o,
    output logic [BW:0]                diff_o
);

    localparam mac_tx_pkg::qw_len_t START_LEN = mac_tx_pkg::qw_len_t'(START_QW);

    mac_tx_pkg::qw_len_t q_len  [2**DESC_AW];
    mac_tx_pkg::ben_t    q_lben [2**DESC_AW];
    logic [DESC_AW:0]    wr_idx, rd_idx, count;
    logic [DESC_AW-1:0]  nxt_idx;
    logic [BW:0]         head_start, next_start, fill_h, fill_n;
    logic                busy, und_seen, trig_cond, rsk_cond, head_done;

    //////////////////////////////////////////////////////////////////////
    // head and next frame view
    //////////////////////////////////////////////////////////////////////
    assign count      = wr_idx - rd_idx;
    assign nxt_idx    = rd_idx[DESC_AW-1:0] + 1'b1;
    assign qw_len_o   = q_len[rd_idx[DESC_AW-1:0]];
    assign lst_ben_o  = q_lben[rd_idx[DESC_AW-1:0]];
    assign next_start = head_start + qw_len_o[BW:0];     // running sum of lengths
    assign fill_h     = prod_i - head_start;
    assign fill_n     = prod_i - next_start;
    assign diff_o     = prod_i - rd_ptr_i;               // qwords ahead of the reader

    assign head_done  = mac_tx_pkg::qw_len_t'(fill_h) >= qw_len_o;
    assign trig_cond  = (count != '0) && !busy &&
                        (mac_tx_pkg::qw_len_t'(fill_h) >= START_LEN || head_done);
    // next frame only counts once the head is fully written
    assign rsk_cond   = (count > 1) && head_done &&
                        (mac_tx_pkg::qw_len_t'(fill_n) >= START_LEN ||
                         mac_tx_pkg::qw_len_t'(fill_n) >= q_len[nxt_idx]);

    always_ff @(posedge clk) begin
        if (desc_push_i) begin
            q_len[wr_idx[DESC_AW-1:0]]  <= desc_len_i;
            q_lben[wr_idx[DESC_AW-1:0]] <= desc_lben_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_idx     <= '0;
            rd_idx     <= '0;
            head_start <= '0;
            busy       <= 1'b0;
            und_seen   <= 1'b0;
            trig_o     <= 1'b0;
            rsk_o      <= 1'b0;
        end else begin
            trig_o <= trig_cond && !trig_o;  // single level pulse per release
            rsk_o  <= rsk_cond;
            if (desc_push_i) begin
                wr_idx <= wr_idx + 1'b1;
            end
            if (trig_o) begin
                busy <= 1'b1;                // idle sender takes it now
            end
            if (tx_underrun_i) begin
                und_seen <= 1'b1;
            end
            if (sync_i) begin
                und_seen <= 1'b0;
                busy     <= rsk_tk_i;        // chained frame stays in flight
                if (!und_seen) begin         // completed, pop head
                    rd_idx     <= rd_idx + 1'b1;
                    head_start <= next_start;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/frame_ingest.sv */
// host write side of the tx path
`timescale 1ns/1ps
`default_nettype none

module frame_ingest #(
    parameter int BW      = 9,
    parameter int DESC_AW = 3
) (
    input  wire                        clk,
    input  wire                        rst,

    // host port
    input  wire                        wr_sof_i,
    input  wire mac_tx_pkg::qw_len_t   wr_len_i,
    input  wire mac_tx_pkg::ben_t      wr_lben_i,
    input  wire                        wr_en_i,
    input  wire mac_tx_pkg::qword_t    wr_data_i,

    // from sender
    input  wire [BW:0]                 committed_cons_i,
    output logic                       buf_full_o,

    // buffer write port
    output logic                       mem_we_o,
    output logic [BW-1:0]              mem_waddr_o,
    output mac_tx_pkg::qword_t         mem_wdata_o,

    // to scheduler
    output logic [BW:0]                prod_o,
    output logic                       desc_push_o,
    output mac_tx_pkg::qw_len_t        desc_len_o,
    output mac_tx_pkg::ben_t           desc_lben_o
);

    logic [BW:0]        used;           // qwords held, not yet committed

    assign used       = prod_o - committed_cons_i;
    assign buf_full_o = (used == (BW+1)'(2**BW));   // wrap bit set, low bits equal

    // write lands at the producer pointer
    assign mem_we_o    = wr_en_i;
    assign mem_waddr_o = prod_o[BW-1:0];
    assign mem_wdata_o = wr_data_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            prod_o      <= '0;
            desc_push_o <= 1'b0;
        end else begin
            desc_push_o <= 1'b0;
            if (wr_en_i) begin
                prod_o <= prod_o + 1'b1;    // visible next clock
            end
            if (wr_sof_i) begin
                desc_push_o <= 1'b1;        // one push per announcement
            end
        end
    end

    // descriptor payload, qualified by desc_push_o
    always_ff @(posedge clk) begin
        if (wr_sof_i) begin
            desc_len_o  <= wr_len_i;
            desc_lben_o <= wr_lben_i;
        end
    end

endmodule

`default_nettype wire

/* design/frame_buffer.sv */
// qword frame buffer
`timescale 1ns/1ps
`default_nettype none

module frame_buffer #(
    parameter int BW = 9
) (
    input  wire                        clk,

    // host write side
    input  wire                        wr_en_i,
    input  wire [BW-1:0]               wr_addr_i,
    input  wire mac_tx_pkg::qword_t    wr_data_i,

    // sender read side
    input  wire [BW-1:0]               rd_addr_i,
    output mac_tx_pkg::qword_t         rd_data_o
);

    mac_tx_pkg::qword_t mem [2**BW];    // circular storage

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // registered read, data one clock after address
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

`default_nettype wire

/* design/tx_buf_pkg.sv */
// frame buffer and scheduling defaults
`default_nettype none

package tx_buf_pkg;

    // buffer address bits, pointers carry one extra wrap bit
    localparam int DEFAULT_BW = 9;

    // descriptor queue address bits, 8 frames queued
    localparam int DEFAULT_DESC_AW = 3;

    // qwords written before a frame may go out cut-through
    localparam int DEFAULT_START_QW = 4;

endpackage

`default_nettype wire

/* design/mac_tx_pkg.sv */
// mac transmit interface types
`default_nettype none

package mac_tx_pkg;

    // one data word of a frame
    typedef logic [63:0] qword_t;

    // byte enables of one qword, bit 0 is byte 0
    typedef logic [7:0] ben_t;

    // frame length counted in qwords
    typedef logic [12:0] qw_len_t;

    // shortest frame the sender pipeline can carry
    localparam int MIN_FRAME_QW = 3;

endpackage

`default_nettype wire
